// ==== rtl/e1000_defs.svh ====
`ifndef E1000_DEFS_SVH
`define E1000_DEFS_SVH

// Byte offset into the register space
`define E1000_REG_AW 16

// Register and cause vector width
`define E1000_DW 32

// PHY interrupt pin synchronizer flops
`define E1000_SYNC_DEPTH 2

`endif

// ==== rtl/e1000_reg_pkg.sv ====
`include "e1000_defs.svh"

package e1000_reg_pkg;

	typedef logic [`E1000_REG_AW-1:0] reg_addr_t;
	typedef logic [`E1000_DW-1:0] reg_data_t;

	// Register byte offsets
	localparam reg_addr_t REG_CTRL = 'h0000;
	localparam reg_addr_t REG_ICR = 'h00C0;
	localparam reg_addr_t REG_ICS = 'h00C8;
	localparam reg_addr_t REG_IMS = 'h00D0;
	localparam reg_addr_t REG_IMC = 'h00D8;

	localparam int unsigned CTRL_RST_BIT = 26; // Device reset
	localparam int unsigned CTRL_PHY_RST_BIT = 31; // PHY reset

	// Value returned on a read
	typedef enum logic [1:0] {
		SEL_CTRL,
		SEL_ICR,
		SEL_IMS,
		SEL_NONE
	} reg_sel_t;

endpackage

// ==== rtl/e1000_intr_pkg.sv ====
`include "e1000_defs.svh"

package e1000_intr_pkg;

	typedef logic [`E1000_DW-1:0] intr_vec_t;

	localparam int unsigned CAUSE_TXDW = 0;
	localparam int unsigned CAUSE_TXQE = 1;
	localparam int unsigned CAUSE_RXDMT0 = 4;
	localparam int unsigned CAUSE_RXO = 6;
	localparam int unsigned CAUSE_RXT0 = 7;
	localparam int unsigned CAUSE_PHYINT = 12;
	localparam int unsigned CAUSE_TXD_LOW = 15;

	// Bits that ICR and IMS actually store
	localparam intr_vec_t CAUSE_IMPL_MASK = (intr_vec_t'(1) << CAUSE_TXDW) |
		(intr_vec_t'(1) << CAUSE_TXQE) | (intr_vec_t'(1) << CAUSE_RXDMT0) |
		(intr_vec_t'(1) << CAUSE_RXO) | (intr_vec_t'(1) << CAUSE_RXT0) |
		(intr_vec_t'(1) << CAUSE_PHYINT) | (intr_vec_t'(1) << CAUSE_TXD_LOW);

endpackage

// ==== rtl/e1000_reg_decode.sv ====
module e1000_reg_decode (
	input logic aclk,
	input logic rst_i,
	input logic req_i,
	input logic we_i,
	input e1000_reg_pkg::reg_addr_t addr_i,
	input e1000_reg_pkg::reg_data_t wdata_i,
	output logic issue_o,
	output logic release_o,
	output logic ctrl_wr_o,
	output logic ics_wr_o,
	output logic ims_wr_o,
	output logic imc_wr_o,
	output logic icr_wr_o,
	output logic icr_rd_o,
	output e1000_reg_pkg::reg_sel_t rd_sel_o,
	output e1000_reg_pkg::reg_data_t cmd_wdata_o
);
	import e1000_reg_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		ISSUE,
		WAIT_DROP
	} state_t;

	state_t state;
	logic cmd_we_q;
	reg_addr_t cmd_addr_q;
	reg_data_t cmd_wdata_q;
	logic dec_ctrl_wr, dec_ics_wr, dec_ims_wr, dec_imc_wr, dec_icr_wr, dec_icr_rd;
	reg_sel_t dec_rd_sel;

	// Command is held from capture until the next transfer
	always_ff @(posedge aclk) begin
		if (state == IDLE && req_i) begin
			cmd_we_q <= we_i;
			cmd_addr_q <= addr_i;
			cmd_wdata_q <= wdata_i;
		end
	end

	// Full offset compare, unknown offsets decode to nothing
	always_comb begin
		dec_ctrl_wr = 1'b0;
		dec_ics_wr = 1'b0;
		dec_ims_wr = 1'b0;
		dec_imc_wr = 1'b0;
		dec_icr_wr = 1'b0;
		dec_icr_rd = 1'b0;
		dec_rd_sel = SEL_NONE;
		case (cmd_addr_q)
			REG_CTRL: begin
				dec_ctrl_wr = cmd_we_q;
				dec_rd_sel = SEL_CTRL;
			end
			REG_ICR: begin
				dec_icr_wr = cmd_we_q;
				dec_icr_rd = !cmd_we_q; // Read clears
				dec_rd_sel = SEL_ICR;
			end
			REG_ICS: dec_ics_wr = cmd_we_q;
			REG_IMS: begin
				dec_ims_wr = cmd_we_q;
				dec_rd_sel = SEL_IMS;
			end
			REG_IMC: dec_imc_wr = cmd_we_q;
			default: ;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (state == ISSUE)
			rd_sel_o <= dec_rd_sel;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			state <= IDLE;
			issue_o <= 1'b0;
			release_o <= 1'b0;
			{ctrl_wr_o, ics_wr_o, ims_wr_o, imc_wr_o, icr_wr_o, icr_rd_o} <= '0;
		end else begin
			issue_o <= 1'b0; // Strobes last one cycle
			release_o <= 1'b0;
			{ctrl_wr_o, ics_wr_o, ims_wr_o, imc_wr_o, icr_wr_o, icr_rd_o} <= '0;
			case (state)
				IDLE: if (req_i) state <= ISSUE;
				ISSUE: begin
					issue_o <= 1'b1;
					ctrl_wr_o <= dec_ctrl_wr;
					ics_wr_o <= dec_ics_wr;
					ims_wr_o <= dec_ims_wr;
					imc_wr_o <= dec_imc_wr;
					icr_wr_o <= dec_icr_wr;
					icr_rd_o <= dec_icr_rd;
					state <= WAIT_DROP;
				end
				WAIT_DROP: begin
					if (!req_i) begin
						release_o <= 1'b1;
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	assign cmd_wdata_o = cmd_wdata_q;

endmodule

// ==== rtl/e1000_intr_ctrl.sv ====
`include "e1000_defs.svh"

module e1000_intr_ctrl (
	input logic aclk,
	input logic rst_i,
	input e1000_intr_pkg::intr_vec_t events_i,
	input logic phy_int_i,
	input logic ics_wr_i,
	input logic ims_wr_i,
	input logic imc_wr_i,
	input logic icr_wr_i,
	input logic icr_rd_i,
	input e1000_reg_pkg::reg_data_t cmd_wdata_i,
	output e1000_intr_pkg::intr_vec_t icr_o,
	output e1000_intr_pkg::intr_vec_t ims_o,
	output logic intr_o
);
	import e1000_intr_pkg::*;

	logic [`E1000_SYNC_DEPTH-1:0] phy_sync;
	intr_vec_t icr_q, ims_q;
	intr_vec_t cause_set, icr_d, ims_d;

	always_ff @(posedge aclk) begin
		if (rst_i)
			phy_sync <= '0;
		else
			phy_sync <= {phy_sync[`E1000_SYNC_DEPTH-2:0], phy_int_i};
	end

	always_comb begin
		cause_set = events_i;
		if (ics_wr_i)
			cause_set = cause_set | cmd_wdata_i;
		if (phy_sync[`E1000_SYNC_DEPTH-1])
			cause_set[CAUSE_PHYINT] = 1'b1;

		// Clears first, so a new cause in the same cycle survives
		icr_d = icr_q;
		if (icr_rd_i)
			icr_d = '0;
		if (icr_wr_i)
			icr_d = icr_d & ~cmd_wdata_i;
		icr_d = (icr_d | cause_set) & CAUSE_IMPL_MASK;

		ims_d = ims_q;
		if (ims_wr_i)
			ims_d = ims_d | cmd_wdata_i;
		if (imc_wr_i)
			ims_d = ims_d & ~cmd_wdata_i;
		ims_d = ims_d & CAUSE_IMPL_MASK;
	end

	always_ff @(posedge aclk) begin
		if (rst_i) begin
			icr_q <= '0;
			ims_q <= '0;
		end else begin
			icr_q <= icr_d;
			ims_q <= ims_d;
		end
	end

	assign icr_o = icr_q;
	assign ims_o = ims_q;
	assign intr_o = |(icr_q & ims_q);

endmodule

// ==== rtl/e1000_reg_response.sv ====
module e1000_reg_response (
	input logic aclk,
	input logic rst_i,
	input logic issue_i,
	input logic release_i,
	input logic ctrl_wr_i,
	input e1000_reg_pkg::reg_data_t cmd_wdata_i,
	input e1000_reg_pkg::reg_sel_t rd_sel_i,
	input e1000_intr_pkg::intr_vec_t icr_i,
	input e1000_intr_pkg::intr_vec_t ims_i,
	output logic ack_o,
	output e1000_reg_pkg::reg_data_t rdata_o,
	output logic reset_request_o,
	output logic phy_reset_o
);
	import e1000_reg_pkg::*;

	logic ctrl_rst_q;
	logic ctrl_phy_rst_q;
	reg_data_t ctrl_val;
	reg_data_t rd_val;

	// Only the two reset bits of CTRL exist
	always_ff @(posedge aclk) begin
		if (rst_i) begin
			ctrl_rst_q <= 1'b0;
			ctrl_phy_rst_q <= 1'b0;
		end else if (ctrl_wr_i) begin
			ctrl_rst_q <= cmd_wdata_i[CTRL_RST_BIT];
			ctrl_phy_rst_q <= cmd_wdata_i[CTRL_PHY_RST_BIT];
		end
	end

	always_comb begin
		ctrl_val = '0;
		ctrl_val[CTRL_RST_BIT] = ctrl_rst_q;
		ctrl_val[CTRL_PHY_RST_BIT] = ctrl_phy_rst_q;
		case (rd_sel_i)
			SEL_CTRL: rd_val = ctrl_val;
			SEL_ICR: rd_val = icr_i; // Value before the read clears it
			SEL_IMS: rd_val = ims_i;
			default: rd_val = '0;
		endcase
	end

	always_ff @(posedge aclk) begin
		if (issue_i)
			rdata_o <= rd_val;
	end

	always_ff @(posedge aclk) begin
		if (rst_i)
			ack_o <= 1'b0;
		else if (issue_i)
			ack_o <= 1'b1;
		else if (release_i)
			ack_o <= 1'b0;
	end

	assign reset_request_o = ctrl_rst_q;
	assign phy_reset_o = ctrl_phy_rst_q | rst_i;

endmodule

// ==== rtl/e1000_lite_top.sv ====
module e1000_lite_top (
	input logic aclk,
	input logic rst_i,
	input logic req_i,
	input logic we_i,
	input e1000_reg_pkg::reg_addr_t addr_i,
	input e1000_reg_pkg::reg_data_t wdata_i,
	input e1000_intr_pkg::intr_vec_t events_i,
	input logic phy_int_i,
	output logic ack_o,
	output e1000_reg_pkg::reg_data_t rdata_o,
	output logic intr_o,
	output logic reset_request_o,
	output logic phy_reset_o
);
	import e1000_reg_pkg::*;
	import e1000_intr_pkg::*;

	logic issue, release_s;
	logic ctrl_wr, ics_wr, ims_wr, imc_wr, icr_wr, icr_rd;
	reg_sel_t rd_sel;
	reg_data_t cmd_wdata;
	intr_vec_t icr_q, ims_q;

	e1000_reg_decode reg_decode_inst (
		.aclk(aclk),
		.rst_i(rst_i),
		.req_i(req_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.issue_o(issue),
		.release_o(release_s),
		.ctrl_wr_o(ctrl_wr),
		.ics_wr_o(ics_wr),
		.ims_wr_o(ims_wr),
		.imc_wr_o(imc_wr),
		.icr_wr_o(icr_wr),
		.icr_rd_o(icr_rd),
		.rd_sel_o(rd_sel),
		.cmd_wdata_o(cmd_wdata)
	);

	e1000_intr_ctrl intr_ctrl_inst (
		.aclk(aclk),
		.rst_i(rst_i),
		.events_i(events_i),
		.phy_int_i(phy_int_i),
		.ics_wr_i(ics_wr),
		.ims_wr_i(ims_wr),
		.imc_wr_i(imc_wr),
		.icr_wr_i(icr_wr),
		.icr_rd_i(icr_rd),
		.cmd_wdata_i(cmd_wdata),
		.icr_o(icr_q),
		.ims_o(ims_q),
		.intr_o(intr_o)
	);

	e1000_reg_response reg_response_inst (
		.aclk(aclk),
		.rst_i(rst_i),
		.issue_i(issue),
		.release_i(release_s),
		.ctrl_wr_i(ctrl_wr),
		.cmd_wdata_i(cmd_wdata),
		.rd_sel_i(rd_sel),
		.icr_i(icr_q),
		.ims_i(ims_q),
		.ack_o(ack_o),
		.rdata_o(rdata_o),
		.reset_request_o(reset_request_o),
		.phy_reset_o(phy_reset_o)
	);

endmodule

// ==== testbench/e1000_lite_sva.sv ====
`include "e1000_defs.svh"

module e1000_lite_sva (
	input logic aclk,
	input logic rst_i,
	input logic req_i,
	input logic ack_o,
	input logic intr_o,
	input logic [`E1000_DW-1:0] icr_i,
	input logic [`E1000_DW-1:0] ims_i
);
	timeunit 1ns;
	timeprecision 1ps;

	// Host must still hold req when ack comes up
	ack_needs_req: assert property (@(posedge aclk) disable iff (rst_i)
		$rose(ack_o) |-> $past(req_i))
		else $error("ack_o rose while req_i was low");

	ack_fall_after_drop: assert property (@(posedge aclk) disable iff (rst_i)
		$fell(ack_o) |-> !$past(req_i))
		else $error("ack_o fell before req_i was seen low");

	intr_matches_causes: assert property (@(posedge aclk) disable iff (rst_i)
		intr_o == |(icr_i & ims_i))
		else $error("intr_o does not match the unmasked causes");

	ack_low_in_reset: assert property (@(posedge aclk)
		rst_i |=> !ack_o)
		else $error("ack_o high after a reset cycle");

endmodule

// ==== testbench/e1000_lite_tb.sv ====
`include "e1000_defs.svh"

module e1000_lite_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import e1000_reg_pkg::*;
	import e1000_intr_pkg::*;

	localparam int PERIOD = 8;
	localparam int RESET_CYCLES = 4;
	localparam int N_XFER = 300;
	localparam int ACK_RISE_EDGES = 3; // Sampling edge plus two
	localparam int ACK_FALL_EDGES = 2;
	localparam int WATCHDOG_CYCLES = (N_XFER + 100) * 40 + 1000;

	logic aclk = 1'b0;
	logic rst_i;
	logic req_i;
	logic we_i;
	reg_addr_t addr_i;
	reg_data_t wdata_i;
	intr_vec_t events_i;
	logic phy_int_i;
	logic ack_o;
	reg_data_t rdata_o;
	logic intr_o;
	logic reset_request_o;
	logic phy_reset_o;

	integer seed = 90;
	int errors = 0;
	int checks = 0;
	int test_start;

	// Register model
	reg_data_t m_ctrl;
	intr_vec_t m_icr;
	intr_vec_t m_ims;

	e1000_lite_top e1000_lite_top_inst (
		.aclk(aclk),
		.rst_i(rst_i),
		.req_i(req_i),
		.we_i(we_i),
		.addr_i(addr_i),
		.wdata_i(wdata_i),
		.events_i(events_i),
		.phy_int_i(phy_int_i),
		.ack_o(ack_o),
		.rdata_o(rdata_o),
		.intr_o(intr_o),
		.reset_request_o(reset_request_o),
		.phy_reset_o(phy_reset_o)
	);

	bind e1000_lite_top e1000_lite_sva sva_inst (
		.aclk(aclk),
		.rst_i(rst_i),
		.req_i(req_i),
		.ack_o(ack_o),
		.intr_o(intr_o),
		.icr_i(icr_q),
		.ims_i(ims_q)
	);

	always #(PERIOD / 2) aclk = ~aclk;

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		$display("timeout: the run did not finish in %0d cycles", WATCHDOG_CYCLES);
		$display("Finished with errors");
		$finish;
	end

	task automatic check_val(input string name, input reg_data_t got, input reg_data_t exp);
		checks++;
		assert (got === exp)
		else begin
			$display("mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic check_edges(input string what, input int got, input int exp);
		checks++;
		assert (got == exp)
		else begin
			$display("handshake: ack_o %s after %0d edges instead of %0d", what, got, exp);
			errors++;
		end
	endtask

	// Applies one access to the model, returns the expected read value
	function automatic reg_data_t model_access(input logic we, input reg_addr_t addr,
		input reg_data_t wdata);
		reg_data_t rd;
		rd = '0;
		case (addr)
			REG_CTRL: begin
				if (we)
					m_ctrl = wdata & ((32'd1 << CTRL_RST_BIT) | (32'd1 << CTRL_PHY_RST_BIT));
				rd = m_ctrl;
			end
			REG_ICR: begin
				if (we) begin
					m_icr = m_icr & ~wdata;
				end else begin
					rd = m_icr; // Value before clear
					m_icr = '0;
				end
			end
			REG_ICS: if (we) m_icr = m_icr | (wdata & CAUSE_IMPL_MASK);
			REG_IMS: begin
				if (we)
					m_ims = m_ims | (wdata & CAUSE_IMPL_MASK);
				rd = m_ims;
			end
			REG_IMC: if (we) m_ims = m_ims & ~wdata;
			default: ;
		endcase
		return rd;
	endfunction

	// One four-phase transfer, checked against the model
	task automatic xfer(input logic we, input reg_addr_t addr, input reg_data_t wdata);
		int n;
		reg_data_t exp;
		reg_data_t got;
		exp = model_access(we, addr, wdata);
		@(negedge aclk);
		req_i = 1'b1;
		we_i = we;
		addr_i = addr;
		wdata_i = wdata;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (!ack_o);
		check_edges("rose", n, ACK_RISE_EDGES);
		got = rdata_o;
		req_i = 1'b0;
		n = 0;
		do begin
			@(negedge aclk);
			n++;
		end while (ack_o);
		check_edges("fell", n, ACK_FALL_EDGES);
		if (!we)
			check_val($sformatf("rdata_o @%h", addr), got, exp);
		check_val("intr_o", reg_data_t'(intr_o), reg_data_t'(|(m_icr & m_ims)));
		check_val("reset_request_o", reg_data_t'(reset_request_o),
			reg_data_t'(m_ctrl[CTRL_RST_BIT]));
		check_val("phy_reset_o", reg_data_t'(phy_reset_o),
			reg_data_t'(m_ctrl[CTRL_PHY_RST_BIT]));
	endtask

	task automatic pulse_events(input intr_vec_t ev);
		@(negedge aclk);
		events_i = ev;
		@(negedge aclk);
		events_i = '0;
		m_icr = m_icr | (ev & CAUSE_IMPL_MASK);
	endtask

	function automatic reg_addr_t unknown_addr();
		reg_addr_t a;
		do begin
			// Half of them one bit away from ICR
			if ($random(seed) & 1)
				a = REG_ICR ^ (reg_addr_t'(1) << ($unsigned($random(seed)) % `E1000_REG_AW));
			else
				a = reg_addr_t'($random(seed));
		end while (a == REG_CTRL || a == REG_ICR || a == REG_ICS || a == REG_IMS ||
			a == REG_IMC);
		return a;
	endfunction

	function automatic reg_addr_t pick_addr();
		case ($unsigned($random(seed)) % 6)
			0: return REG_CTRL;
			1: return REG_ICR;
			2: return REG_ICS;
			3: return REG_IMS;
			4: return REG_IMC;
			default: return unknown_addr();
		endcase
	endfunction

	task automatic end_test(input string name);
		$display("test %s done, %0d errors", name, errors - test_start);
		test_start = errors;
	endtask

	initial begin
		rst_i = 1'b1;
		req_i = 1'b0;
		we_i = 1'b0;
		addr_i = '0;
		wdata_i = '0;
		events_i = '0;
		phy_int_i = 1'b0;
		m_ctrl = '0;
		m_icr = '0;
		m_ims = '0;
		test_start = 0;
		repeat (RESET_CYCLES) @(negedge aclk);
		check_val("phy_reset_o", reg_data_t'(phy_reset_o), 32'd1); // High while in reset
		check_val("ack_o", reg_data_t'(ack_o), '0);
		check_val("intr_o", reg_data_t'(intr_o), '0);
		check_val("reset_request_o", reg_data_t'(reset_request_o), '0);
		rst_i = 1'b0;
		end_test("reset");

		for (int i = 0; i < 6; i++) begin
			xfer(1'b1, REG_CTRL, $random(seed));
			xfer(1'b0, REG_CTRL, '0);
		end
		end_test("ctrl");

		xfer(1'b1, REG_ICS, $random(seed));
		xfer(1'b0, REG_ICR, '0);
		xfer(1'b0, REG_ICR, '0);
		xfer(1'b1, REG_ICS, 32'hffff_ffff);
		xfer(1'b1, REG_ICR, $random(seed));
		xfer(1'b0, REG_ICR, '0);
		end_test("icr");

		for (int i = 0; i < 5; i++) begin
			xfer(1'b1, REG_IMS, $random(seed));
			xfer(1'b1, REG_IMC, $random(seed));
			xfer(1'b1, REG_ICS, $random(seed));
			xfer(1'b0, REG_IMS, '0);
		end
		end_test("mask");

		for (int i = 0; i < 5; i++) begin
			pulse_events($random(seed));
			xfer(1'b0, REG_ICR, '0);
		end
		@(negedge aclk);
		phy_int_i = 1'b1;
		repeat (4) @(negedge aclk);
		phy_int_i = 1'b0;
		m_icr[CAUSE_PHYINT] = 1'b1;
		repeat (4) @(negedge aclk); // Let the synchronizer drain
		xfer(1'b0, REG_ICR, '0);
		end_test("causes");

		xfer(1'b1, REG_ICS, 32'hffff_ffff);
		xfer(1'b0, REG_ICS, '0);
		xfer(1'b0, REG_IMC, '0);
		for (int i = 0; i < 5; i++) begin
			xfer(1'b1, unknown_addr(), $random(seed));
			xfer(1'b0, unknown_addr(), '0);
		end
		xfer(1'b0, REG_CTRL, '0);
		xfer(1'b0, REG_IMS, '0);
		xfer(1'b0, REG_ICR, '0);
		end_test("handshake");

		for (int i = 0; i < N_XFER; i++) begin
			if ($unsigned($random(seed)) % 4 == 0)
				pulse_events($random(seed));
			xfer(1'(($random(seed)) & 1), pick_addr(), $random(seed));
		end
		end_test("random");

		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("Finished with no errors");
		else
			$display("Finished with errors");
		$finish;
	end

endmodule

// ==== filelist.f ====
+incdir+rtl
rtl/e1000_reg_pkg.sv
rtl/e1000_intr_pkg.sv
rtl/e1000_reg_decode.sv
rtl/e1000_intr_ctrl.sv
rtl/e1000_reg_response.sv
rtl/e1000_lite_top.sv
testbench/e1000_lite_sva.sv
testbench/e1000_lite_tb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f filelist.f --top-module e1000_lite_tb -o simv \
	&& ./obj_dir/simv | tee /dev/stderr | grep -q "^Finished with no errors$" \
	&& echo "PASS" \
	|| { echo "FAIL"; exit 1; }
